//--- Bender.yml
package:
  name: cache

sources:
  - hw/cache_pkg.sv
  - hw/front_end.sv
  - hw/cache_way.sv
  - hw/way_resolver.sv
  - hw/cache_ctrl.sv
  - hw/cache_top.sv
  - target: simulation
    files:
      - test/cache_tb.sv

//--- build.f
hw/cache_pkg.sv
hw/front_end.sv
hw/cache_way.sv
hw/way_resolver.sv
hw/cache_ctrl.sv
hw/cache_top.sv
test/cache_tb.sv

//--- hw/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl
   import cache_pkg::*;
(
   input  wire             clk,
   input  wire             reset,
   input  wire             ctrl_valid,
   input  wire ctrl_addr_t ctrl_addr,
   input  wire             ctrl_clear,   // write, zeroes all counters
   input  wire             hit_ev,
   input  wire             miss_ev,
   input  wire             write_ev,
   output logic            ctrl_ready,
   output word_t           ctrl_rdata
);

   word_t hit_cnt_q;
   word_t miss_cnt_q;
   word_t write_cnt_q;

   // saturate at all ones
   function automatic word_t sat_inc(word_t v);
      return (&v) ? v : v + word_t'(1);
   endfunction

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         hit_cnt_q   <= '0;
         miss_cnt_q  <= '0;
         write_cnt_q <= '0;
      end
      else if (ctrl_valid && ctrl_clear)
      begin
         hit_cnt_q   <= '0;   // same-cycle events dropped
         miss_cnt_q  <= '0;
         write_cnt_q <= '0;
      end
      else
      begin
         if (hit_ev)
            hit_cnt_q <= sat_inc(hit_cnt_q);
         if (miss_ev)
            miss_cnt_q <= sat_inc(miss_cnt_q);
         if (write_ev)
            write_cnt_q <= sat_inc(write_cnt_q);
      end
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrl_ready <= 1'b0;
      else
         ctrl_ready <= ctrl_valid;   // fixed one-cycle answer
   end

   always_ff @(posedge clk)
   begin
      if (ctrl_valid)
      begin
         if (ctrl_clear)
            ctrl_rdata <= '0;
         else
         begin
            case (ctrl_addr)
               2'd0:    ctrl_rdata <= hit_cnt_q;
               2'd1:    ctrl_rdata <= miss_cnt_q;
               2'd2:    ctrl_rdata <= write_cnt_q;
               default: ctrl_rdata <= '0;   // slot 3 unused
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- hw/cache_pkg.sv
`default_nettype none

package cache_pkg;

   ////////////////////
   // sizes
   ////////////////////
   localparam int BYTE_W      = 8;
   localparam int DATA_W      = 32;              // one word per line
   localparam int NBYTES      = DATA_W / BYTE_W; // byte strobes per word
   localparam int ADDR_W      = 10;              // word address, data side only
   localparam int NWAYS       = 4;
   localparam int NSETS       = 16;
   localparam int IDX_W       = 4;               // log2 of NSETS
   localparam int TAG_W       = ADDR_W - IDX_W;  // 6
   localparam int CTRL_ADDR_W = 2;               // four counter slots

   ////////////////////
   // vector types
   ////////////////////
   typedef logic [DATA_W-1:0]      word_t;
   typedef logic [NBYTES-1:0]      strb_t;
   typedef logic [ADDR_W-1:0]      waddr_t;
   typedef logic [IDX_W-1:0]       idx_t;
   typedef logic [TAG_W-1:0]       tag_t;
   typedef logic [CTRL_ADDR_W-1:0] ctrl_addr_t;
   typedef logic [NWAYS-1:0]       way_sel_t;   // one-hot over ways

   // request as seen by every way and the resolver
   typedef struct packed {
      logic   valid;
      waddr_t addr;
      word_t  wdata;
      strb_t  wstrb;   // nonzero means write
   } fe_req_t;

   // per-way lookup result
   typedef struct packed {
      logic  hit;
      word_t rdata;
   } way_rsp_t;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,     // way outputs valid here
      MEM_READ,   // refill fetch
      MEM_WRITE,  // write-through
      DONE        // ready to processor
   } rsv_state_t;

   // set index sits in the low address bits
   function automatic idx_t addr_idx(waddr_t a);
      return a[IDX_W-1:0];
   endfunction

   function automatic tag_t addr_tag(waddr_t a);
      return a[ADDR_W-1 -: TAG_W];
   endfunction

endpackage

`default_nettype wire

//--- hw/cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module cache_top
   import cache_pkg::*;
(
   input  wire            clk,
   input  wire            reset,
   // processor side
   input  wire            valid,
   input  wire [ADDR_W:0] addr,
   input  wire word_t     wdata,
   input  wire strb_t     wstrb,
   output logic           ready,
   output word_t          rdata,
   // backing memory
   output logic           mem_valid,
   output waddr_t         mem_addr,
   output word_t          mem_wdata,
   output strb_t          mem_wstrb,
   input  wire word_t     mem_rdata,
   input  wire            mem_ready
);

   fe_req_t    fe_req;
   way_rsp_t   way_rsp [NWAYS];
   way_sel_t   fill_sel;
   way_sel_t   upd_sel;
   word_t      fill_data;
   logic       data_ready;
   word_t      data_rdata;
   logic       ctrl_valid;
   ctrl_addr_t ctrl_addr;
   logic       ctrl_clear;
   logic       ctrl_ready;
   word_t      ctrl_rdata;
   logic       hit_ev;
   logic       miss_ev;
   logic       write_ev;

   front_end front_end_i (
      .clk        (clk),
      .reset      (reset),
      .valid      (valid),
      .addr       (addr),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .data_ready (data_ready),
      .data_rdata (data_rdata),
      .ctrl_ready (ctrl_ready),
      .ctrl_rdata (ctrl_rdata),
      .ready      (ready),
      .rdata      (rdata),
      .fe_req     (fe_req),
      .ctrl_valid (ctrl_valid),
      .ctrl_addr  (ctrl_addr),
      .ctrl_clear (ctrl_clear)
   );

   ////////////////////
   // ways
   ////////////////////
   for (genvar g = 0; g < NWAYS; g++)
   begin : g_way
      cache_way way_i (
         .clk       (clk),
         .reset     (reset),
         .fe_req    (fe_req),
         .fill_en   (fill_sel[g]),
         .fill_data (fill_data),
         .upd_en    (upd_sel[g]),
         .rsp       (way_rsp[g])
      );
   end

   way_resolver way_resolver_i (
      .clk        (clk),
      .reset      (reset),
      .fe_req     (fe_req),
      .way_rsp    (way_rsp),
      .mem_rdata  (mem_rdata),
      .mem_ready  (mem_ready),
      .fill_sel   (fill_sel),
      .upd_sel    (upd_sel),
      .fill_data  (fill_data),
      .data_ready (data_ready),
      .data_rdata (data_rdata),
      .mem_valid  (mem_valid),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb),
      .hit_ev     (hit_ev),
      .miss_ev    (miss_ev),
      .write_ev   (write_ev)
   );

   cache_ctrl cache_ctrl_i (
      .clk        (clk),
      .reset      (reset),
      .ctrl_valid (ctrl_valid),
      .ctrl_addr  (ctrl_addr),
      .ctrl_clear (ctrl_clear),
      .hit_ev     (hit_ev),
      .miss_ev    (miss_ev),
      .write_ev   (write_ev),
      .ctrl_ready (ctrl_ready),
      .ctrl_rdata (ctrl_rdata)
   );

endmodule

`default_nettype wire

//--- hw/cache_way.sv
`timescale 1ns/1ps
`default_nettype none

module cache_way
   import cache_pkg::*;
(
   input  wire       clk,
   input  wire       reset,
   input  wire       fe_req_t fe_req,
   input  wire       fill_en,      // refill from memory
   input  wire word_t fill_data,
   input  wire       upd_en,       // write hit, merge bytes
   output way_rsp_t  rsp
);

   logic [NSETS-1:0] valid_q;
   tag_t             tag_mem  [NSETS];
   word_t            data_mem [NSETS];
   idx_t             idx;
   tag_t             tag;
   logic             rd_valid_q;
   tag_t             rd_tag_q;
   tag_t             req_tag_q;   // tag of the looked-up address
   word_t            rd_data_q;

   assign idx = addr_idx(fe_req.addr);
   assign tag = addr_tag(fe_req.addr);

   // valid bits, cleared on reset only
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         valid_q    <= '0;
         rd_valid_q <= 1'b0;
      end
      else
      begin
         if (fill_en)
            valid_q[idx] <= 1'b1;
         rd_valid_q <= valid_q[idx];
      end
   end

   // tag and data arrays
   always_ff @(posedge clk)
   begin
      if (fill_en)
      begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= fill_data;   // whole line
      end
      else if (upd_en)
      begin
         for (int b = 0; b < NBYTES; b++)
         begin
            if (fe_req.wstrb[b])
               data_mem[idx][BYTE_W*b +: BYTE_W] <= fe_req.wdata[BYTE_W*b +: BYTE_W];
         end
      end
   end

   // synchronous read, result seen one cycle on
   always_ff @(posedge clk)
   begin
      rd_tag_q  <= tag_mem[idx];
      rd_data_q <= data_mem[idx];
      req_tag_q <= tag;
   end

   // tag compare after the read register
   always_comb
   begin
      rsp.hit   = rd_valid_q && (rd_tag_q == req_tag_q);
      rsp.rdata = rd_data_q;
   end

endmodule

`default_nettype wire

//--- hw/front_end.sv
`timescale 1ns/1ps
`default_nettype none

module front_end
   import cache_pkg::*;
(
   input  wire            clk,
   input  wire            reset,
   input  wire            valid,
   input  wire [ADDR_W:0] addr,        // msb selects control space
   input  wire word_t     wdata,
   input  wire strb_t     wstrb,
   input  wire            data_ready,
   input  wire word_t     data_rdata,
   input  wire            ctrl_ready,
   input  wire word_t     ctrl_rdata,
   output logic           ready,
   output word_t          rdata,
   output fe_req_t        fe_req,
   output logic           ctrl_valid,
   output ctrl_addr_t     ctrl_addr,
   output logic           ctrl_clear
);

   logic   ctrl_sel;
   logic   data_valid;     // live data-side request
   logic   ctrl_busy_q;    // control request already issued
   logic   held_valid_q;
   waddr_t held_addr_q;
   word_t  held_wdata_q;
   strb_t  held_wstrb_q;

   assign ctrl_sel   = addr[ADDR_W];
   assign data_valid = valid & ~ctrl_sel;

   ////////////////////
   // control side
   ////////////////////

   // the master holds valid until ready and only its first cycle counts
   assign ctrl_valid = valid & ctrl_sel & ~ctrl_busy_q;
   assign ctrl_addr  = addr[CTRL_ADDR_W-1:0];
   assign ctrl_clear = |wstrb;   // any write clears

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         ctrl_busy_q <= 1'b0;
      else
         ctrl_busy_q <= ctrl_valid;   // ready comes next cycle
   end

   ////////////////////
   // request hold
   ////////////////////

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
         held_valid_q <= 1'b0;
      else if (data_ready)
         held_valid_q <= 1'b0;   // finished request is not replayed
      else if (data_valid)
         held_valid_q <= 1'b1;
   end

   // captured once and kept through memory stalls
   always_ff @(posedge clk)
   begin
      if (data_valid && !held_valid_q)
      begin
         held_addr_q  <= addr[ADDR_W-1:0];
         held_wdata_q <= wdata;
         held_wstrb_q <= wstrb;
      end
   end

   // live port in the first cycle and the held copy after it
   always_comb
   begin
      if (held_valid_q)
      begin
         fe_req.valid = 1'b1;
         fe_req.addr  = held_addr_q;
         fe_req.wdata = held_wdata_q;
         fe_req.wstrb = held_wstrb_q;
      end
      else
      begin
         fe_req.valid = data_valid;
         fe_req.addr  = addr[ADDR_W-1:0];
         fe_req.wdata = wdata;
         fe_req.wstrb = wstrb;
      end
   end

   ////////////////////
   // response merge
   ////////////////////
   assign ready = data_ready | ctrl_ready;
   assign rdata = ctrl_ready ? ctrl_rdata : data_rdata;

   // only one request is outstanding and the two sides never answer together
   a_single_rsp: assert property (@(posedge clk) disable iff (reset)
      !(data_ready && ctrl_ready))
      else $error("data and control responses collide");

endmodule

`default_nettype wire

//--- hw/way_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module way_resolver
   import cache_pkg::*;
(
   input  wire           clk,
   input  wire           reset,
   input  wire fe_req_t  fe_req,
   input  wire way_rsp_t way_rsp [NWAYS],
   input  wire word_t    mem_rdata,
   input  wire           mem_ready,
   output way_sel_t      fill_sel,
   output way_sel_t      upd_sel,
   output word_t         fill_data,
   output logic          data_ready,
   output word_t         data_rdata,
   output logic          mem_valid,
   output waddr_t        mem_addr,
   output word_t         mem_wdata,
   output strb_t         mem_wstrb,
   output logic          hit_ev,
   output logic          miss_ev,
   output logic          write_ev
);

   rsv_state_t state_q;
   rsv_state_t state_d;
   way_sel_t   hit_vec;
   way_sel_t   rr_q;       // victim pointer, one-hot
   word_t      hit_data;
   word_t      rdata_q;
   logic       is_write;
   logic       any_hit;

   ////////////////////
   // hit select
   ////////////////////
   always_comb
   begin
      hit_data = '0;
      for (int w = 0; w < NWAYS; w++)
      begin
         hit_vec[w] = way_rsp[w].hit;
         if (way_rsp[w].hit)
            hit_data = hit_data | way_rsp[w].rdata;   // one-hot or
      end
   end

   assign is_write = |fe_req.wstrb;
   assign any_hit  = |hit_vec;

   ////////////////////
   // FSM
   ////////////////////
   always_comb
   begin
      state_d = state_q;
      case (state_q)
         IDLE:
         begin
            if (fe_req.valid)
               state_d = LOOKUP;
         end
         LOOKUP:
         begin
            if (is_write)
               state_d = MEM_WRITE;   // no allocate, always write through
            else if (any_hit)
               state_d = DONE;
            else
               state_d = MEM_READ;
         end
         MEM_READ,
         MEM_WRITE:
         begin
            if (mem_ready)
               state_d = DONE;
         end
         default:
            state_d = IDLE;   // DONE
      endcase
   end

   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state_q <= IDLE;
         rr_q    <= way_sel_t'(1);   // way 0
      end
      else
      begin
         state_q <= state_d;
         if (state_q == MEM_READ && mem_ready)
            rr_q <= {rr_q[NWAYS-2:0], rr_q[NWAYS-1]};   // advance per fill
      end
   end

   // read data for the processor
   always_ff @(posedge clk)
   begin
      if (state_q == LOOKUP && any_hit)
         rdata_q <= hit_data;
      else if (state_q == MEM_READ && mem_ready)
         rdata_q <= mem_rdata;
   end

   // way controls
   assign fill_sel  = (state_q == MEM_READ && mem_ready) ? rr_q : '0;
   assign upd_sel   = (state_q == LOOKUP && is_write) ? hit_vec : '0;
   assign fill_data = mem_rdata;

   // memory port, fields come from the held request
   assign mem_valid = (state_q == MEM_READ) || (state_q == MEM_WRITE);
   assign mem_addr  = fe_req.addr;
   assign mem_wdata = fe_req.wdata;
   assign mem_wstrb = (state_q == MEM_WRITE) ? fe_req.wstrb : '0;   // zero on reads

   assign data_ready = (state_q == DONE);
   assign data_rdata = rdata_q;

   // counter events, reads give hit or miss, writes only count as writes
   assign hit_ev   = (state_q == LOOKUP) && !is_write && any_hit;
   assign miss_ev  = (state_q == LOOKUP) && !is_write && !any_hit;
   assign write_ev = (state_q == LOOKUP) && is_write;

   a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
      state_q == LOOKUP |-> $onehot0(hit_vec))
      else $error("more than one way hit");

   a_mem_hold: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> mem_valid)
      else $error("mem_valid dropped before mem_ready");

   // front end must keep the request stable under back-pressure
   a_mem_addr_stable: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> $stable(mem_addr))
      else $error("mem_addr changed while waiting");

endmodule

`default_nettype wire

//--- test/cache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cache_tb
   import cache_pkg::*;
();

   localparam int NREQ        = 400;
   localparam int RESET_CYC   = 10;
   localparam int TIMEOUT_CYC = NREQ * 12 + RESET_CYC;
   localparam int MEM_WORDS   = 1 << ADDR_W;

   logic            clk;
   logic            reset;
   logic            valid;
   logic [ADDR_W:0] addr;      // msb picks control space
   word_t           wdata;
   strb_t           wstrb;
   logic            ready;
   word_t           rdata;
   logic            mem_valid;
   waddr_t          mem_addr;
   word_t           mem_wdata;
   strb_t           mem_wstrb;
   word_t           mem_rdata;
   logic            mem_ready;

   integer seed;
   word_t  bmem    [MEM_WORDS];   // backing memory as written through the mem port
   word_t  ref_mem [MEM_WORDS];   // expected contents from the stimulus
   logic   m_valid [NWAYS][NSETS];
   tag_t   m_tag   [NWAYS][NSETS];
   int     m_rr;                  // model victim pointer
   int     m_hits;
   int     m_misses;
   int     m_writes;
   int     mem_rd_cnt;
   int     mem_wr_cnt;
   waddr_t mem_last_addr;
   word_t  mem_last_wdata;
   strb_t  mem_last_wstrb;
   int     n_req;
   int     ready_cnt;

   cache_top dut_i (
      .clk       (clk),
      .reset     (reset),
      .valid     (valid),
      .addr      (addr),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .ready     (ready),
      .rdata     (rdata),
      .mem_valid (mem_valid),
      .mem_addr  (mem_addr),
      .mem_wdata (mem_wdata),
      .mem_wstrb (mem_wstrb),
      .mem_rdata (mem_rdata),
      .mem_ready (mem_ready)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   ////////////////////
   // helpers
   ////////////////////
   task automatic fail_run(input string why);
      $display("ERROR at %0t: %s", $time, why);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input word_t got, input word_t exp);
      if (got !== exp)
      begin
         $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
         fail_run("value mismatch");
      end
   endtask

   // address-dependent start pattern
   function automatic word_t fill_word(input waddr_t a);
      return {a, 6'h15, ~a, 6'h2a};
   endfunction

   function automatic word_t merge_bytes(input word_t old, input word_t wd, input strb_t ws);
      word_t res;
      res = old;
      for (int b = 0; b < NBYTES; b++)
      begin
         if (ws[b])
            res[8*b +: 8] = wd[8*b +: 8];
      end
      return res;
   endfunction

   // model lookup returns -1 on a miss
   function automatic int find_way(input waddr_t a);
      for (int w = 0; w < NWAYS; w++)
      begin
         if (m_valid[w][a[IDX_W-1:0]] && m_tag[w][a[IDX_W-1:0]] == a[ADDR_W-1 -: TAG_W])
            return w;
      end
      return -1;
   endfunction

   // one processor transaction with lat in cycles from request to ready
   task automatic do_request(input logic is_ctrl, input waddr_t a, input word_t wd,
                             input strb_t ws, output word_t rd, output int lat);
      int cyc;
      cyc = 0;
      @(posedge clk);
      #1;
      addr  = {is_ctrl, a};
      wdata = wd;
      wstrb = ws;
      valid = 1'b1;
      @(negedge clk);
      while (!ready)
      begin
         cyc++;
         @(negedge clk);
      end
      rd  = rdata;
      lat = cyc;
      @(posedge clk);
      #1;
      valid = 1'b0;
      @(negedge clk);
      check_eq("ready after pulse", word_t'(ready), 0);   // single-cycle pulse
      n_req++;
   endtask

   task automatic ctrl_read_check(input ctrl_addr_t ca, input word_t exp);
      word_t rd;
      int    lat;
      int    rd0;
      int    wr0;
      rd0 = mem_rd_cnt;
      wr0 = mem_wr_cnt;
      do_request(1'b1, waddr_t'(ca), '0, '0, rd, lat);
      check_eq("ctrl latency", word_t'(lat), 1);
      check_eq("ctrl rdata", rd, exp);
      check_eq("mem reads on ctrl", word_t'(mem_rd_cnt), word_t'(rd0));
      check_eq("mem writes on ctrl", word_t'(mem_wr_cnt), word_t'(wr0));
   endtask

   ////////////////////
   // memory model
   ////////////////////
   initial
   begin : mem_model
      int lat;
      mem_ready = 1'b0;
      mem_rdata = '0;
      forever
      begin
         @(negedge clk);
         if (!reset && mem_valid)
         begin
            mem_last_addr  = mem_addr;    // as first presented
            mem_last_wdata = mem_wdata;
            mem_last_wstrb = mem_wstrb;
            if (mem_last_wstrb != '0)     // counted when first raised
               mem_wr_cnt++;
            else
               mem_rd_cnt++;
            lat = 1 + ($unsigned($random(seed)) % 4);
            repeat (lat) @(posedge clk);
            #1;
            if (mem_last_wstrb != '0)
               bmem[mem_last_addr] = merge_bytes(bmem[mem_last_addr], mem_last_wdata,
                                                 mem_last_wstrb);
            else
               mem_rdata = bmem[mem_last_addr];
            mem_ready = 1'b1;
            @(posedge clk);
            #1;
            mem_ready = 1'b0;
         end
      end
   end

   // ready pulses counted against requests at the end
   always @(negedge clk)
   begin
      if (!reset && ready)
         ready_cnt++;
   end

   initial
   begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYC)
      begin
         @(posedge clk);
         cycles++;
      end
      fail_run("timeout, the processor port never answered");
   end

   ////////////////////
   // stimulus
   ////////////////////
   initial
   begin : stimulus
      int     kind;
      int     way;
      int     lat;
      int     rd0;
      int     wr0;
      word_t  rnd;
      word_t  wd;
      word_t  rd;
      word_t  exp;
      waddr_t a;
      strb_t  ws;
      idx_t   idx;
      seed  = 32'h19ac5943;
      reset = 1'b1;
      valid = 1'b0;
      addr  = '0;
      wdata = '0;
      wstrb = '0;
      m_rr = 0;
      m_hits = 0;
      m_misses = 0;
      m_writes = 0;
      mem_rd_cnt = 0;
      mem_wr_cnt = 0;
      n_req = 0;
      ready_cnt = 0;
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         bmem[i]    = fill_word(waddr_t'(i));
         ref_mem[i] = fill_word(waddr_t'(i));
      end
      for (int w = 0; w < NWAYS; w++)
      begin
         for (int s = 0; s < NSETS; s++)
         begin
            m_valid[w][s] = 1'b0;
            m_tag[w][s]   = '0;
         end
      end
      repeat (RESET_CYC) @(posedge clk);
      #1;
      reset = 1'b0;

      while (n_req < NREQ)
      begin
         kind = $unsigned($random(seed)) % 16;
         rnd  = $random(seed);
         wd   = $random(seed);
         a    = {rnd[5:3], 3'b101, 1'b0, rnd[2:0]};   // 8 tags over 8 sets give 64 words
         idx  = a[IDX_W-1:0];
         rd0  = mem_rd_cnt;
         wr0  = mem_wr_cnt;
         if (kind < 7)
         begin
            way = find_way(a);
            do_request(1'b0, a, wd, '0, rd, lat);
            check_eq("rdata", rd, ref_mem[a]);
            check_eq("mem writes on read", word_t'(mem_wr_cnt), word_t'(wr0));
            if (way >= 0)
            begin
               m_hits++;
               check_eq("read hit latency", word_t'(lat), 2);
               check_eq("mem reads on hit", word_t'(mem_rd_cnt), word_t'(rd0));
            end
            else
            begin
               m_misses++;
               check_eq("mem reads on miss", word_t'(mem_rd_cnt), word_t'(rd0 + 1));
               check_eq("mem_addr", word_t'(mem_last_addr), word_t'(a));
               check_eq("mem_wstrb", word_t'(mem_last_wstrb), 0);
               m_valid[m_rr][idx] = 1'b1;   // refill into victim
               m_tag[m_rr][idx]   = a[ADDR_W-1 -: TAG_W];
               m_rr = (m_rr + 1) % NWAYS;
            end
         end
         else if (kind < 13)
         begin
            ws = rnd[9:6];
            if (ws == '0)
               ws = 4'b1000;
            do_request(1'b0, a, wd, ws, rd, lat);
            ref_mem[a] = merge_bytes(ref_mem[a], wd, ws);   // no allocate
            m_writes++;
            check_eq("mem writes on write", word_t'(mem_wr_cnt), word_t'(wr0 + 1));
            check_eq("mem reads on write", word_t'(mem_rd_cnt), word_t'(rd0));
            check_eq("mem_addr", word_t'(mem_last_addr), word_t'(a));
            check_eq("mem_wdata", mem_last_wdata, wd);
            check_eq("mem_wstrb", word_t'(mem_last_wstrb), word_t'(ws));
         end
         else if (kind < 15)
         begin
            case (rnd[7:6])
               2'd0:    exp = word_t'(m_hits);
               2'd1:    exp = word_t'(m_misses);
               2'd2:    exp = word_t'(m_writes);
               default: exp = '0;
            endcase
            ctrl_read_check(rnd[7:6], exp);
         end
         else
         begin
            // clear and then expect zero from all three counters
            do_request(1'b1, waddr_t'(rnd[7:6]), wd, 4'hf, rd, lat);
            check_eq("ctrl clear latency", word_t'(lat), 1);
            check_eq("mem reads on clear", word_t'(mem_rd_cnt), word_t'(rd0));
            check_eq("mem writes on clear", word_t'(mem_wr_cnt), word_t'(wr0));
            m_hits = 0;
            m_misses = 0;
            m_writes = 0;
            for (int c = 0; c < 3; c++)
               ctrl_read_check(ctrl_addr_t'(c), '0);
         end
         repeat ($unsigned($random(seed)) % 2) @(posedge clk);
      end

      repeat (3) @(posedge clk);
      check_eq("ready pulses", word_t'(ready_cnt), word_t'(n_req));
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire
